// ==== dcache_defs.svh ====
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cpu word and byte address widths
`define DC_DATA_W       32
`define DC_ADDR_W       32

// byte lanes per word
`define DC_STRB_W       (`DC_DATA_W / 8)
`define DC_BYTE_BITS    2

// line geometry, 4 words per line
`define DC_OFFSET_BITS  2
`define DC_LINE_WORDS   (1 << `DC_OFFSET_BITS)

// 16 sets, direct mapped
`define DC_INDEX_BITS   4
`define DC_SETS         (1 << `DC_INDEX_BITS)

// tag is whatever is left above index, offset and byte bits
`define DC_TAG_W        (`DC_ADDR_W - `DC_INDEX_BITS - `DC_OFFSET_BITS - `DC_BYTE_BITS)

// backing memory depth in words
`define DC_MEM_WORDS    1024

`endif

// ==== dcache_pkg.sv ====
`include "dcache_defs.svh"

package dcache_pkg;

    // cpu request, held stable while req_valid is high
    typedef struct packed {
        logic                   we;
        logic [`DC_ADDR_W-1:0]  addr;
        logic [`DC_DATA_W-1:0]  wdata;
        logic [`DC_STRB_W-1:0]  wmask;
    } dc_req_t;

    // cpu response payload, strobe travels beside it
    typedef struct packed {
        logic [`DC_DATA_W-1:0]  rdata;
    } dc_rsp_t;

    // shared by AR and AW
    // len is beats minus one, as on AXI
    typedef struct packed {
        logic [`DC_ADDR_W-1:0]  addr;
        logic [7:0]             len;
    } axi_a_t;

    // write data beat
    typedef struct packed {
        logic [`DC_DATA_W-1:0]  data;
        logic [`DC_STRB_W-1:0]  strb;
        logic                   last;
    } axi_w_t;

    // read data beat
    typedef struct packed {
        logic [`DC_DATA_W-1:0]  data;
        logic [1:0]             resp;
        logic                   last;
    } axi_r_t;

    // cache controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_ADDR,
        WB_DATA,
        WB_RESP,
        RF_ADDR,
        RF_DATA,
        RESPOND
    } dc_state_e;

endpackage

// ==== dcache_tag_array.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tag_array (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`DC_INDEX_BITS-1:0]   set_index,
    input  logic [`DC_TAG_W-1:0]        tag,
    input  logic                        tag_update,
    input  logic                        set_dirty,
    output logic                        hit,
    output logic [`DC_TAG_W-1:0]        victim_tag,
    output logic                        victim_dirty
);

    logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];
    logic [`DC_SETS-1:0]  valid;
    logic [`DC_SETS-1:0]  dirty;

    // combinational lookup
    assign victim_tag   = tag_mem[set_index];
    assign hit          = valid[set_index] && (victim_tag == tag);
    // only a valid line can need write-back
    assign victim_dirty = valid[set_index] && dirty[set_index];

    // status bits per set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_update) begin
            // freshly refilled line is clean
            valid[set_index] <= 1'b1;
            dirty[set_index] <= 1'b0;
        end else if (set_dirty) begin
            dirty[set_index] <= 1'b1;
        end
    end

    // tag itself only changes on refill
    always_ff @(posedge clk) begin
        if (tag_update) begin
            tag_mem[set_index] <= tag;
        end
    end

endmodule

// ==== dcache_data_array.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_data_array (
    input  logic                        clk,
    input  logic [`DC_INDEX_BITS-1:0]   set_index,
    input  logic [`DC_OFFSET_BITS-1:0]  word_offset,
    input  logic                        cpu_write,
    input  logic [`DC_STRB_W-1:0]       wmask,
    input  logic [`DC_DATA_W-1:0]       wdata,
    input  logic                        refill_write,
    input  logic [`DC_DATA_W-1:0]       refill_word,
    output logic [`DC_DATA_W-1:0]       rdata,
    output logic [`DC_DATA_W-1:0]       wb_word
);

    localparam int WORDS  = `DC_SETS * `DC_LINE_WORDS;
    localparam int WORD_AW = `DC_INDEX_BITS + `DC_OFFSET_BITS;

    logic [`DC_DATA_W-1:0] line_mem [WORDS];
    logic [WORD_AW-1:0]    word_addr;
    logic [`DC_DATA_W-1:0] cur_word;
    logic [`DC_DATA_W-1:0] merged;

    // set and word select into a flat array
    assign word_addr = {set_index, word_offset};
    assign cur_word  = line_mem[word_addr];

    // same word serves the cpu read and the write-back beat
    assign rdata   = cur_word;
    assign wb_word = cur_word;

    // byte merge of store data over the stored word
    always_comb begin
        merged = cur_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (wmask[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    // refill beats are written whole
    always_ff @(posedge clk) begin
        if (refill_write) begin
            line_mem[word_addr] <= refill_word;
        end else if (cpu_write) begin
            line_mem[word_addr] <= merged;
        end
    end

endmodule

// ==== axi_burst_mem.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module axi_burst_mem
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    ar_valid,
    output logic    ar_ready,
    input  axi_a_t  ar,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_a_t  aw,
    input  logic    w_valid,
    output logic    w_ready,
    input  axi_w_t  w,
    output logic    r_valid,
    input  logic    r_ready,
    output axi_r_t  r,
    output logic    b_valid,
    input  logic    b_ready
);

    localparam int MEM_AW     = $clog2(`DC_MEM_WORDS);
    localparam int FIRST_WAIT = 2;

    logic [`DC_DATA_W-1:0] mem [`DC_MEM_WORDS];
    logic                  rd_active;
    logic                  wr_active;
    logic [MEM_AW-1:0]     rd_ptr;
    logic [MEM_AW-1:0]     wr_ptr;
    logic [7:0]            rd_left;
    logic [1:0]            wait_cnt;
    logic                  idle;

    // each word holds its own byte address
    initial begin
        for (int i = 0; i < `DC_MEM_WORDS; i++) begin
            mem[i] = `DC_DATA_W'(i << `DC_BYTE_BITS);
        end
    end

    // one burst at a time, reads win a tie
    assign idle     = !rd_active && !wr_active && !b_valid;
    assign ar_ready = idle;
    assign aw_ready = idle && !ar_valid;

    // beats only after the first-beat wait runs out
    assign r_valid = rd_active && (wait_cnt == '0);
    assign r.data  = mem[rd_ptr];
    assign r.resp  = 2'b00;
    assign r.last  = (rd_left == 8'd0);
    assign w_ready = wr_active && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_valid   <= 1'b0;
            wait_cnt  <= '0;
        end else begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
            if (ar_valid && ar_ready) begin
                rd_active <= 1'b1;
                wait_cnt  <= 2'(FIRST_WAIT);
            end else if (aw_valid && aw_ready) begin
                wr_active <= 1'b1;
                wait_cnt  <= 2'(FIRST_WAIT);
            end
            if (r_valid && r_ready && r.last) begin
                rd_active <= 1'b0;
            end
            // write burst ends on the last flag, then B
            if (w_valid && w_ready && w.last) begin
                wr_active <= 1'b0;
                b_valid   <= 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    // read pointer, wraps modulo depth
    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_ptr  <= ar.addr[`DC_BYTE_BITS +: MEM_AW];
            rd_left <= ar.len;
        end else if (r_valid && r_ready) begin
            rd_ptr  <= rd_ptr + 1'b1;
            rd_left <= rd_left - 1'b1;
        end
    end

    // write pointer and strobed store
    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            wr_ptr <= aw.addr[`DC_BYTE_BITS +: MEM_AW];
        end else if (w_valid && w_ready) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (w.strb[b]) begin
                    mem[wr_ptr][8*b +: 8] <= w.data[8*b +: 8];
                end
            end
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

endmodule

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    // cpu port
    input  logic                        req_valid,
    output logic                        req_ready,
    input  dc_req_t                     req,
    output logic                        rsp_valid,
    output dc_rsp_t                     rsp,
    // tag array
    output logic [`DC_INDEX_BITS-1:0]   set_index,
    output logic [`DC_TAG_W-1:0]        tag,
    input  logic                        hit,
    input  logic [`DC_TAG_W-1:0]        victim_tag,
    input  logic                        victim_dirty,
    output logic                        tag_update,
    output logic                        set_dirty,
    // data array
    output logic                        cpu_write,
    output logic [`DC_STRB_W-1:0]       wmask,
    output logic [`DC_DATA_W-1:0]       wdata,
    output logic                        refill_write,
    output logic [`DC_OFFSET_BITS-1:0]  word_offset,
    output logic [`DC_DATA_W-1:0]       refill_word,
    input  logic [`DC_DATA_W-1:0]       rdata,
    input  logic [`DC_DATA_W-1:0]       wb_word,
    // axi master
    output logic                        ar_valid,
    input  logic                        ar_ready,
    output axi_a_t                      ar,
    output logic                        aw_valid,
    input  logic                        aw_ready,
    output axi_a_t                      aw,
    output logic                        w_valid,
    input  logic                        w_ready,
    output axi_w_t                      w,
    input  logic                        r_valid,
    output logic                        r_ready,
    input  axi_r_t                      r,
    input  logic                        b_valid,
    output logic                        b_ready
);

    localparam int LINE_LSB = `DC_OFFSET_BITS + `DC_BYTE_BITS;

    dc_state_e                  state;
    dc_req_t                    req_q;
    logic [`DC_OFFSET_BITS-1:0] beat;
    logic [`DC_OFFSET_BITS-1:0] req_offset;
    logic                       in_burst;

    // split the held address
    assign set_index  = req_q.addr[LINE_LSB +: `DC_INDEX_BITS];
    assign tag        = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign req_offset = req_q.addr[`DC_BYTE_BITS +: `DC_OFFSET_BITS];

    // one request in flight, latched on accept
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            beat  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    beat <= '0;
                    // dirty victim must go out before the refill
                    if (hit) begin
                        state <= RESPOND;
                    end else if (victim_dirty) begin
                        state <= WB_ADDR;
                    end else begin
                        state <= RF_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (aw_ready) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (w_ready) begin
                        // counter wraps to zero for the refill
                        beat <= beat + 1'b1;
                        if (w.last) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (b_valid) begin
                        state <= RF_ADDR;
                    end
                end
                RF_ADDR: begin
                    if (ar_ready) begin
                        state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (r.last) begin
                            state <= RESPOND;
                        end
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // cpu handshake
    assign req_ready = (state == IDLE);
    assign rsp_valid = (state == RESPOND);
    assign rsp.rdata = rdata;

    // bursts index the line by beat, otherwise by request offset
    assign in_burst    = (state == WB_DATA) || (state == RF_DATA);
    assign word_offset = in_burst ? beat : req_offset;

    // pending store lands in RESPOND, hit or after refill
    assign cpu_write = (state == RESPOND) && req_q.we;
    assign set_dirty = cpu_write;
    assign wmask     = req_q.wmask;
    assign wdata     = req_q.wdata;

    // refill beats go straight into the line
    assign refill_write = (state == RF_DATA) && r_valid;
    assign refill_word  = r.data;
    // new tag on the final beat, dirty cleared
    assign tag_update   = refill_write && r.last;
    assign r_ready      = (state == RF_DATA);

    // line-aligned bursts of one full line
    assign ar_valid = (state == RF_ADDR);
    assign ar.addr  = {tag, set_index, {LINE_LSB{1'b0}}};
    assign ar.len   = 8'(`DC_LINE_WORDS - 1);

    // write-back address from the victim tag
    assign aw_valid = (state == WB_ADDR);
    assign aw.addr  = {victim_tag, set_index, {LINE_LSB{1'b0}}};
    assign aw.len   = 8'(`DC_LINE_WORDS - 1);

    assign w_valid = (state == WB_DATA);
    assign w.data  = wb_word;
    assign w.strb  = '1;
    assign w.last  = (beat == `DC_OFFSET_BITS'(`DC_LINE_WORDS - 1));
    assign b_ready = (state == WB_RESP);

endmodule

// ==== dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid,
    output logic    req_ready,
    input  dc_req_t req,
    output logic    rsp_valid,
    output dc_rsp_t rsp
);

    // controller to arrays
    logic [`DC_INDEX_BITS-1:0]  set_index;
    logic [`DC_TAG_W-1:0]       tag;
    logic                       hit;
    logic [`DC_TAG_W-1:0]       victim_tag;
    logic                       victim_dirty;
    logic                       tag_update;
    logic                       set_dirty;
    logic                       cpu_write;
    logic [`DC_STRB_W-1:0]      wmask;
    logic [`DC_DATA_W-1:0]      wdata;
    logic                       refill_write;
    logic [`DC_OFFSET_BITS-1:0] word_offset;
    logic [`DC_DATA_W-1:0]      refill_word;
    logic [`DC_DATA_W-1:0]      rdata;
    logic [`DC_DATA_W-1:0]      wb_word;

    // axi between controller and memory
    logic   ar_valid;
    logic   ar_ready;
    axi_a_t ar;
    logic   aw_valid;
    logic   aw_ready;
    axi_a_t aw;
    logic   w_valid;
    logic   w_ready;
    axi_w_t w;
    logic   r_valid;
    logic   r_ready;
    axi_r_t r;
    logic   b_valid;
    logic   b_ready;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req          (req),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp),
        .set_index    (set_index),
        .tag          (tag),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .tag_update   (tag_update),
        .set_dirty    (set_dirty),
        .cpu_write    (cpu_write),
        .wmask        (wmask),
        .wdata        (wdata),
        .refill_write (refill_write),
        .word_offset  (word_offset),
        .refill_word  (refill_word),
        .rdata        (rdata),
        .wb_word      (wb_word),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .ar           (ar),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .aw           (aw),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .w            (w),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .r            (r),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

    dcache_tag_array u_tag_array (
        .clk          (clk),
        .reset        (reset),
        .set_index    (set_index),
        .tag          (tag),
        .tag_update   (tag_update),
        .set_dirty    (set_dirty),
        .hit          (hit),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    dcache_data_array u_data_array (
        .clk          (clk),
        .set_index    (set_index),
        .word_offset  (word_offset),
        .cpu_write    (cpu_write),
        .wmask        (wmask),
        .wdata        (wdata),
        .refill_write (refill_write),
        .refill_word  (refill_word),
        .rdata        (rdata),
        .wb_word      (wb_word)
    );

    axi_burst_mem u_mem (
        .clk      (clk),
        .reset    (reset),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 8 ns period
    localparam real HALF_PERIOD  = 4.0;
    localparam int  RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // reset released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_tb
    import dcache_pkg::*;
();

    localparam int COLD_READS     = 8;
    localparam int MERGE_CASES    = 4;
    localparam int RAND_OPS       = 300;
    localparam int TOTAL_OPS      = COLD_READS + 2 * MERGE_CASES + 3 + RAND_OPS;
    // 40 cycles per operation is well above a dirty miss
    localparam int TIMEOUT_CYCLES = TOTAL_OPS * 40;
    localparam int HIT_LATENCY    = 2;
    localparam int TAG_LSB        = `DC_INDEX_BITS + `DC_OFFSET_BITS + `DC_BYTE_BITS;
    localparam logic [`DC_STRB_W-1:0] MERGE_MASKS [MERGE_CASES] =
        '{4'b0001, 4'b0110, 4'b1000, 4'b1011};

    logic    clk;
    logic    reset;
    logic    req_valid;
    logic    req_ready;
    dc_req_t req;
    logic    rsp_valid;
    dc_rsp_t rsp;

    // reference copy of backing memory, kept coherent by the tb
    logic [`DC_DATA_W-1:0] shadow [`DC_MEM_WORDS];
    integer seed;
    int     errors;
    int     checks;
    int     tests_run;
    int     tests_failed;
    int     cycles;
    logic   rsp_prev;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    dcache_top u_dcache_top (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // word slot in memory, wraps modulo depth
    function automatic int word_index(input logic [`DC_ADDR_W-1:0] addr);
        return int'((addr >> `DC_BYTE_BITS) % `DC_MEM_WORDS);
    endfunction

    // byte lanes under mask take the new data
    function automatic logic [`DC_DATA_W-1:0] merge_bytes(
        input logic [`DC_DATA_W-1:0] old_word,
        input logic [`DC_DATA_W-1:0] new_word,
        input logic [`DC_STRB_W-1:0] mask
    );
        logic [`DC_DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (mask[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    // one request, returns the response word and cycles from accept to rsp_valid
    task automatic cache_access(
        input  logic                  we,
        input  logic [`DC_ADDR_W-1:0] addr,
        input  logic [`DC_DATA_W-1:0] wdata,
        input  logic [`DC_STRB_W-1:0] wmask,
        output logic [`DC_DATA_W-1:0] rdata,
        output int                    latency
    );
        int idx;
        idx = word_index(addr);
        @(negedge clk);
        req_valid = 1'b1;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        req.wmask = wmask;
        // ready seen here means acceptance on the next rising edge
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (we) begin
            shadow[idx] = merge_bytes(shadow[idx], wdata, wmask);
        end
        latency = 1;
        while (!rsp_valid) begin
            @(negedge clk);
            latency++;
        end
        rdata = rsp.rdata;
    endtask

    // read and compare with the shadow copy
    task automatic read_and_check(input logic [`DC_ADDR_W-1:0] addr, output int latency);
        logic [`DC_DATA_W-1:0] got;
        logic [`DC_DATA_W-1:0] expected;
        cache_access(1'b0, addr, '0, '0, got, latency);
        expected = shadow[word_index(addr)];
        checks++;
        assert (got === expected)
        else begin
            errors++;
            $display("** Error at %0t: rsp.rdata (addr %h) expected %h actual %h",
                     $time, addr, expected, got);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // rsp_valid is a strobe, never two cycles back to back
    always @(negedge clk) begin
        if (reset) begin
            rsp_prev <= 1'b0;
        end else begin
            assert (!(rsp_valid && rsp_prev))
            else begin
                errors++;
                $display("rsp_valid stayed high for two cycles in a row at %0t", $time);
            end
            rsp_prev <= rsp_valid;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout, run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_ADDR_W-1:0] addr_b;
        logic [`DC_DATA_W-1:0] data;
        logic [`DC_DATA_W-1:0] rdata;
        logic [`DC_STRB_W-1:0] mask;
        logic                  we;
        int                    lat;
        int                    mark;
        seed         = 32'h195af46e;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        req_valid    = 1'b0;
        req          = '0;
        // memory starts with every word equal to its byte address
        for (int i = 0; i < `DC_MEM_WORDS; i++) begin
            shadow[i] = i * (`DC_DATA_W / 8);
        end

        // idle handshake one cycle after reset falls
        @(negedge reset);
        @(negedge clk);
        mark = errors;
        checks += 2;
        assert (req_ready === 1'b1)
        else begin
            errors++;
            $display("** Error at %0t: req_ready expected 1 actual %b", $time, req_ready);
        end
        assert (rsp_valid === 1'b0)
        else begin
            errors++;
            $display("** Error at %0t: rsp_valid expected 0 actual %b", $time, rsp_valid);
        end
        finish_test("reset state", mark);

        // distinct lines, all must miss
        mark = errors;
        for (int k = 0; k < COLD_READS; k++) begin
            addr = k * 32'h34;
            read_and_check(addr, lat);
            checks++;
            assert (lat > HIT_LATENCY)
            else begin
                errors++;
                $display("cold read of %h answered in %0d cycles, like a hit", addr, lat);
            end
        end
        finish_test("cold reads", mark);

        // partial stores, read back as hits
        mark = errors;
        for (int k = 0; k < MERGE_CASES; k++) begin
            addr = 32'h200 + k * 32'h44;
            data = $random(seed);
            cache_access(1'b1, addr, data, MERGE_MASKS[k], rdata, lat);
            read_and_check(addr, lat);
            checks++;
            assert (lat == HIT_LATENCY)
            else begin
                errors++;
                $display("read of %h after a store took %0d cycles, not a hit", addr, lat);
            end
        end
        finish_test("byte merge", mark);

        // same set, next tag up, forces the dirty line out
        mark = errors;
        addr   = 32'h0C8;
        addr_b = addr + (32'h1 << TAG_LSB);
        data   = $random(seed);
        cache_access(1'b1, addr, data, '1, rdata, lat);
        read_and_check(addr_b, lat);
        read_and_check(addr, lat);
        checks++;
        assert (lat > HIT_LATENCY)
        else begin
            errors++;
            $display("evicted line %h still answered as a hit", addr);
        end
        finish_test("dirty eviction", mark);

        // 4 tags per set inside the low 1 KiB
        mark = errors;
        for (int n = 0; n < RAND_OPS; n++) begin
            we   = 1'($random(seed));
            addr = $random(seed) & 32'h0000_03FC;
            data = $random(seed);
            mask = `DC_STRB_W'($random(seed));
            if (we) begin
                cache_access(1'b1, addr, data, mask, rdata, lat);
            end else begin
                read_and_check(addr, lat);
            end
        end
        finish_test("random mix", mark);

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== dcache.f ====
+incdir+.
dcache_pkg.sv
dcache_tag_array.sv
dcache_data_array.sv
axi_burst_mem.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

SRCS := $(wildcard *.sv *.svh)

.PHONY: all run check clean

all: check

# rebuilt only when a source or the file list changes
obj_dir/Vdcache_tb: dcache.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb \
		-f dcache.f -o Vdcache_tb

run: obj_dir/Vdcache_tb
	./obj_dir/Vdcache_tb | tee sim.log

# fails unless the pass line is in the log
check: run
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
